//--- common/s2mm_macros.svh
// fifo depths, almost-full margins, frame length limit and control record constants
`ifndef S2MM_MACROS_SVH
`define S2MM_MACROS_SVH

// fifo depths in entries
`define S2MM_DATA_DEPTH 64
`define S2MM_GOOD_DEPTH 32
`define S2MM_INFO_DEPTH 8
`define S2MM_CTRL_DEPTH 16

// longest frame in 64-bit beats, also the data/good almost-full margin
`define S2MM_MAX_BEATS 8

// status record length in words, also the ctrl almost-full margin
`define S2MM_CTRL_WORDS 6

// tag in the top nibble of record word 0
`define S2MM_FLAGS_TAG 5

`endif

//--- common/s2mm_pkg.sv
// shared packed types: stored rx beat, per-frame info byte, control record word
package s2mm_pkg;

   // one beat as held in the data and good fifos
   // last sits in bit 72, keep in 71:64
   typedef struct packed
   {
      // end of frame marker
      logic        last;
      // byte enables, thermometer from bit 0 up
      logic [7:0]  keep;
      // payload, byte 0 in the low bits
      logic [63:0] data;
   } rx_beat_t;

   // one status byte per frame, pushed after the last beat
   typedef struct packed
   {
      // frame failed at the mac, discard it
      logic       bad;
      // unused, written as zero
      logic [5:0] rsvd;
      // multicast destination
      logic       mcast;
   } rx_info_t;

   // one word of the six-word status record
   typedef struct packed
   {
      // set on the final record word only
      logic        last;
      // always all ones
      logic [3:0]  keep;
      // record payload
      logic [31:0] data;
   } ctrl_word_t;

   // sizes as seen by the fifo instances
   localparam int RX_BEAT_W = $bits(rx_beat_t);
   localparam int RX_INFO_W = $bits(rx_info_t);
   localparam int CTRL_WORD_W = $bits(ctrl_word_t);

endpackage

//--- ifm_out/ifm_out_fsm.sv
// out fsm: drops bad frames, forwards good beats, counts bytes, emits the status record
`include "s2mm_macros.svh"

module ifm_out_fsm (
   input  logic                  s2mm_clk,
   input  logic                  s2mm_resetn,
   input  s2mm_pkg::rx_beat_t    data_rdata,
   output logic                  data_rden,
   input  s2mm_pkg::rx_info_t    info_rdata,
   input  logic                  info_empty,
   output logic                  info_rden,
   output s2mm_pkg::rx_beat_t    good_wdata,
   output logic                  good_wren,
   input  logic                  good_afull,
   output s2mm_pkg::ctrl_word_t  ctrl_wdata,
   output logic                  ctrl_wren,
   input  logic                  ctrl_afull
);

   import s2mm_pkg::*;

   localparam int WCNT_W = $clog2(`S2MM_CTRL_WORDS);
   // record word slots
   localparam logic [WCNT_W-1:0] W_FLAGS = WCNT_W'(0);
   localparam logic [WCNT_W-1:0] W_MCAST = WCNT_W'(3);
   localparam logic [WCNT_W-1:0] W_LAST  = WCNT_W'(`S2MM_CTRL_WORDS - 1);

   typedef enum logic [2:0]
   {
      S_IDLE,
      S_WAIT,
      S_DROP,
      S_EOF,
      S_DONE
   } state_t;

   state_t            state;
   state_t            state_ns;
   logic              ready_sof;
   logic [WCNT_W-1:0] wcnt;
   rx_info_t          info_reg;
   logic [3:0]        beat_bytes;
   logic [15:0]       byte_total;
   ctrl_word_t        rec_word;

   // a whole frame info is stored and both outputs can take a full frame
   assign ready_sof = !info_empty && !good_afull && !ctrl_afull;

   always_ff @(posedge s2mm_clk or negedge s2mm_resetn)
   begin
      if (!s2mm_resetn)
      begin
         state <= S_IDLE;
      end
      else
      begin
         state <= state_ns;
      end
   end

   always_comb
   begin
      state_ns = state;
      case (state)
         S_IDLE:
         begin
            if (ready_sof)
            begin
               state_ns = info_rdata.bad ? S_DROP : S_WAIT;
            end
         end
         S_WAIT:
         begin
            if (data_rdata.last)
            begin
               state_ns = S_EOF;
            end
         end
         S_DROP:
         begin
            if (data_rdata.last)
            begin
               state_ns = S_DONE;
            end
         end
         S_EOF:
         begin
            if (wcnt == W_LAST)
            begin
               state_ns = S_DONE;
            end
         end
         default:
         begin
            state_ns = S_IDLE;
         end
      endcase
   end

   // first beat popped at start, then one per cycle to the last
   assign data_rden = (state == S_IDLE && ready_sof) || (state == S_WAIT) ||
                      (state == S_DROP);
   // info leaves with the frame's last beat
   assign info_rden = (state == S_WAIT || state == S_DROP) && data_rdata.last;

   always_ff @(posedge s2mm_clk or negedge s2mm_resetn)
   begin
      if (!s2mm_resetn)
      begin
         good_wren <= 1'b0;
         ctrl_wren <= 1'b0;
         wcnt      <= '0;
      end
      else
      begin
         // forwarded beat written one cycle after its pop
         good_wren <= (state == S_IDLE && ready_sof && !info_rdata.bad) ||
                      (state == S_WAIT);
         // one record word per eof cycle
         ctrl_wren <= (state == S_EOF);
         if (state == S_IDLE)
         begin
            wcnt <= '0;
         end
         else if (state == S_EOF)
         begin
            wcnt <= wcnt + 1'b1;
         end
      end
   end

   // payload path, aligned with good_wren
   always_ff @(posedge s2mm_clk)
   begin
      good_wdata <= data_rdata;
      beat_bytes <= 4'($countones(data_rdata.keep));
      ctrl_wdata <= rec_word;
      // info held from start of frame
      if (state == S_IDLE)
      begin
         info_reg <= info_rdata;
      end
      // byte total restarts each frame
      if (state == S_IDLE)
      begin
         byte_total <= '0;
      end
      else if (good_wren)
      begin
         byte_total <= byte_total + 16'(beat_bytes);
      end
   end

   // record word selected by the eof counter
   always_comb
   begin
      rec_word      = '0;
      rec_word.keep = 4'hf;
      case (wcnt)
         W_FLAGS:
         begin
            rec_word.data[31:28] = 4'(`S2MM_FLAGS_TAG);
         end
         W_MCAST:
         begin
            rec_word.data[7] = ~info_reg.mcast;
            rec_word.data[6] = info_reg.mcast;
         end
         W_LAST:
         begin
            rec_word.last       = 1'b1;
            rec_word.data[15:0] = byte_total;
         end
         default:
         begin
            rec_word.data = '0;
         end
      endcase
   end

   // frame info still queued means its data is fully stored
   a_data_present: assert property (@(posedge s2mm_clk) disable iff (!s2mm_resetn)
      data_rden |-> !info_empty)
      else $error("ifm_out_fsm: data pop without stored frame");
   // a started frame must reach its last beat within the frame limit
   a_frame_len: assert property (@(posedge s2mm_clk) disable iff (!s2mm_resetn)
      (state == S_IDLE && data_rden) |-> ##[1:`S2MM_MAX_BEATS - 1] info_rden)
      else $error("ifm_out_fsm: frame longer than limit");

endmodule

//--- source/rx_frame_ingest.sv
// mac beat ingest: data fifo writes, overflow frame drop, frame info byte push
module rx_frame_ingest (
   input  logic                s2mm_clk,
   input  logic                s2mm_resetn,
   input  logic                mac_valid,
   input  s2mm_pkg::rx_beat_t  mac_beat,
   input  logic                mac_error,
   input  logic                mac_mcast,
   input  logic                data_afull,
   output logic                data_wren,
   output s2mm_pkg::rx_beat_t  data_wdata,
   output logic                info_wren,
   output s2mm_pkg::rx_info_t  info_wdata,
   output logic [15:0]         ovf_drops
);

   import s2mm_pkg::*;

   // next valid beat opens a frame
   logic first_beat;
   // current frame is being thrown away
   logic dropping;
   // drop decision for the beat on the bus now
   logic drop_now;

   // decided once at the first beat, held for the rest of the frame
   assign drop_now = first_beat ? data_afull : dropping;

   assign data_wren  = mac_valid && !drop_now;
   assign data_wdata = mac_beat;

   always_ff @(posedge s2mm_clk or negedge s2mm_resetn)
   begin
      if (!s2mm_resetn)
      begin
         first_beat <= 1'b1;
         dropping   <= 1'b0;
         info_wren  <= 1'b0;
         ovf_drops  <= '0;
      end
      else
      begin
         // info lands one cycle after the last data beat
         info_wren <= mac_valid && mac_beat.last && !drop_now;
         if (mac_valid)
         begin
            first_beat <= mac_beat.last;
            dropping   <= drop_now;
            // one count per discarded frame
            if (first_beat && data_afull)
            begin
               ovf_drops <= ovf_drops + 16'd1;
            end
         end
      end
   end

   // status sampled alongside the last beat
   always_ff @(posedge s2mm_clk)
   begin
      if (mac_valid && mac_beat.last)
      begin
         info_wdata.bad   <= mac_error;
         info_wdata.rsvd  <= '0;
         info_wdata.mcast <= mac_mcast;
      end
   end

   // downstream byte counting expects a nonzero thermometer keep
   a_keep_therm: assert property (@(posedge s2mm_clk) disable iff (!s2mm_resetn)
      mac_valid |-> (mac_beat.keep != 8'h00) &&
                    ((mac_beat.keep & (mac_beat.keep + 8'd1)) == 8'h00))
      else $error("rx_frame_ingest: bad keep %h", mac_beat.keep);

endmodule

//--- source/s2mm_rx_path.sv
// s2mm rx top: ingest, data/info/good/ctrl fifos and the out fsm
`include "s2mm_macros.svh"

module s2mm_rx_path (
   input  logic                  s2mm_clk,
   input  logic                  s2mm_resetn,
   input  logic                  mac_valid,
   input  s2mm_pkg::rx_beat_t    mac_beat,
   input  logic                  mac_error,
   input  logic                  mac_mcast,
   input  logic                  good_rden,
   output s2mm_pkg::rx_beat_t    good_rdata,
   output logic                  good_empty,
   input  logic                  ctrl_rden,
   output s2mm_pkg::ctrl_word_t  ctrl_rdata,
   output logic                  ctrl_empty,
   output logic [15:0]           ovf_drops
);

   import s2mm_pkg::*;

   // ingest to data fifo to fsm
   logic       data_wren;
   rx_beat_t   data_wdata;
   logic       data_afull;
   logic       data_rden;
   rx_beat_t   data_rdata;
   // ingest to info fifo to fsm
   logic       info_wren;
   rx_info_t   info_wdata;
   logic       info_rden;
   rx_info_t   info_rdata;
   logic       info_empty;
   // fsm to output fifos
   logic       good_wren;
   rx_beat_t   good_wdata;
   logic       good_afull;
   logic       ctrl_wren;
   ctrl_word_t ctrl_wdata;
   logic       ctrl_afull;

   rx_frame_ingest u_ingest (
      .s2mm_clk    (s2mm_clk),
      .s2mm_resetn (s2mm_resetn),
      .mac_valid   (mac_valid),
      .mac_beat    (mac_beat),
      .mac_error   (mac_error),
      .mac_mcast   (mac_mcast),
      .data_afull  (data_afull),
      .data_wren   (data_wren),
      .data_wdata  (data_wdata),
      .info_wren   (info_wren),
      .info_wdata  (info_wdata),
      .ovf_drops   (ovf_drops)
   );

   // fsm never checks data empty, info ordering covers it
   sync_fifo #(.DEPTH(`S2MM_DATA_DEPTH), .AFULL_MARGIN(`S2MM_MAX_BEATS), .T(rx_beat_t))
   u_data_fifo (
      .s2mm_clk (s2mm_clk), .s2mm_resetn (s2mm_resetn),
      .wren (data_wren), .wdata (data_wdata), .rden (data_rden), .rdata (data_rdata),
      .empty (), .afull (data_afull)
   );

   // data afull guards this one too
   sync_fifo #(.DEPTH(`S2MM_INFO_DEPTH), .AFULL_MARGIN(1), .T(rx_info_t))
   u_info_fifo (
      .s2mm_clk (s2mm_clk), .s2mm_resetn (s2mm_resetn),
      .wren (info_wren), .wdata (info_wdata), .rden (info_rden), .rdata (info_rdata),
      .empty (info_empty), .afull ()
   );

   sync_fifo #(.DEPTH(`S2MM_GOOD_DEPTH), .AFULL_MARGIN(`S2MM_MAX_BEATS), .T(rx_beat_t))
   u_good_fifo (
      .s2mm_clk (s2mm_clk), .s2mm_resetn (s2mm_resetn),
      .wren (good_wren), .wdata (good_wdata), .rden (good_rden), .rdata (good_rdata),
      .empty (good_empty), .afull (good_afull)
   );

   sync_fifo #(.DEPTH(`S2MM_CTRL_DEPTH), .AFULL_MARGIN(`S2MM_CTRL_WORDS), .T(ctrl_word_t))
   u_ctrl_fifo (
      .s2mm_clk (s2mm_clk), .s2mm_resetn (s2mm_resetn),
      .wren (ctrl_wren), .wdata (ctrl_wdata), .rden (ctrl_rden), .rdata (ctrl_rdata),
      .empty (ctrl_empty), .afull (ctrl_afull)
   );

   ifm_out_fsm u_out_fsm (
      .s2mm_clk    (s2mm_clk),
      .s2mm_resetn (s2mm_resetn),
      .data_rdata  (data_rdata),
      .data_rden   (data_rden),
      .info_rdata  (info_rdata),
      .info_empty  (info_empty),
      .info_rden   (info_rden),
      .good_wdata  (good_wdata),
      .good_wren   (good_wren),
      .good_afull  (good_afull),
      .ctrl_wdata  (ctrl_wdata),
      .ctrl_wren   (ctrl_wren),
      .ctrl_afull  (ctrl_afull)
   );

endmodule

//--- source/sync_fifo.sv
// synchronous fifo with first-word-fall-through read, empty and almost-full flags
module sync_fifo #(
   parameter int  DEPTH        = 16,
   parameter int  AFULL_MARGIN = 1,
   parameter type T            = logic [7:0]
) (
   input  logic s2mm_clk,
   input  logic s2mm_resetn,
   input  logic wren,
   input  T     wdata,
   input  logic rden,
   output T     rdata,
   output logic empty,
   output logic afull
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   // storage, no reset
   T mem [DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             full;
   logic             do_wr;
   logic             do_rd;

   // pointer advance with wrap at DEPTH
   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign full  = (count == CNT_W'(DEPTH));
   assign empty = (count == '0);
   // free space below margin
   assign afull = (DEPTH - int'(count)) < AFULL_MARGIN;

   assign do_wr = wren && !full;
   assign do_rd = rden && !empty;

   // head entry always on the read port
   assign rdata = mem[rd_ptr];

   always_ff @(posedge s2mm_clk)
   begin
      if (do_wr)
      begin
         mem[wr_ptr] <= wdata;
      end
   end

   always_ff @(posedge s2mm_clk or negedge s2mm_resetn)
   begin
      if (!s2mm_resetn)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_wr)
         begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (do_rd)
         begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         // occupancy moves only on a lone push or pop
         case ({do_wr, do_rd})
            2'b10: count <= count + 1'b1;
            2'b01: count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // producers must respect almost-full, consumers must respect empty
   a_no_overflow: assert property (@(posedge s2mm_clk) disable iff (!s2mm_resetn)
      wren |-> !full)
      else $error("sync_fifo: write while full");
   a_no_underflow: assert property (@(posedge s2mm_clk) disable iff (!s2mm_resetn)
      rden |-> !empty)
      else $error("sync_fifo: read while empty");

endmodule

//--- tb.f
+incdir+common
common/s2mm_pkg.sv
source/sync_fifo.sv
source/rx_frame_ingest.sv
ifm_out/ifm_out_fsm.sv
source/s2mm_rx_path.sv
verification/tb_s2mm_rx_path.sv

//--- verification/tb_s2mm_rx_path.sv
// testbench for the s2mm rx path: lfsr stimulus, frame model, output pop checks, watchdog
`include "s2mm_macros.svh"

module tb_s2mm_rx_path;

   import s2mm_pkg::*;

   localparam int NUM_FRAMES = 40;
   localparam int MIN_GAP = 16;
   localparam int DRAIN_CYCLES = 40;
   // 40 cycles per frame worst case at 10 units, plus reset and drain margin
   localparam int WATCHDOG_TIME = NUM_FRAMES * 40 * 10 + 2000;

   logic        s2mm_clk;
   logic        s2mm_resetn;
   logic        mac_valid;
   rx_beat_t    mac_beat;
   logic        mac_error;
   logic        mac_mcast;
   logic        good_rden;
   rx_beat_t    good_rdata;
   logic        good_empty;
   logic        ctrl_rden;
   ctrl_word_t  ctrl_rdata;
   logic        ctrl_empty;
   logic [15:0] ovf_drops;

   // lfsr state
   logic [15:0] lfsr;
   // model queues, filled at stimulus time
   rx_beat_t    exp_good [$];
   ctrl_word_t  exp_ctrl [$];
   int          good_errs;
   int          ctrl_errs;
   int          other_errs;
   int          good_frames;
   int          bad_frames;

   s2mm_rx_path DUT (
      .s2mm_clk    (s2mm_clk),
      .s2mm_resetn (s2mm_resetn),
      .mac_valid   (mac_valid),
      .mac_beat    (mac_beat),
      .mac_error   (mac_error),
      .mac_mcast   (mac_mcast),
      .good_rden   (good_rden),
      .good_rdata  (good_rdata),
      .good_empty  (good_empty),
      .ctrl_rden   (ctrl_rden),
      .ctrl_rdata  (ctrl_rdata),
      .ctrl_empty  (ctrl_empty),
      .ovf_drops   (ovf_drops)
   );

   always #5 s2mm_clk = ~s2mm_clk;

   // fibonacci lfsr, taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // n fresh bits, one lfsr step each
   task automatic take_bits(input int n, output logic [63:0] bits);
      bits = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr_next(lfsr);
         bits = {bits[62:0], lfsr[0]};
      end
   endtask

   // expected six-word status record of one good frame
   task automatic push_record(input logic mc, input logic [15:0] total);
      ctrl_word_t w;
      for (int i = 0; i < `S2MM_CTRL_WORDS; i++)
      begin
         w = '0;
         w.keep = 4'hf;
         // tag word first
         if (i == 0)
         begin
            w.data[31:28] = 4'(`S2MM_FLAGS_TAG);
         end
         // multicast word, inverse in bit 7
         if (i == 3)
         begin
            w.data[7] = ~mc;
            w.data[6] = mc;
         end
         // closing word carries the byte total
         if (i == `S2MM_CTRL_WORDS - 1)
         begin
            w.last = 1'b1;
            w.data[15:0] = total;
         end
         exp_ctrl.push_back(w);
      end
   endtask

   // pre-edge values: a strobe high here pops the word shown on rdata
   task automatic check_pops();
      rx_beat_t   eb;
      ctrl_word_t ec;
      if (good_rden)
      begin
         assert (exp_good.size() != 0)
         else
         begin
            other_errs++;
            $display("good fifo delivered a beat that no good frame should produce");
         end
         if (exp_good.size() != 0)
         begin
            eb = exp_good.pop_front();
            assert (good_rdata == eb)
            else
            begin
               good_errs++;
               $display("Error: good_rdata got %h expected %h", good_rdata, eb);
            end
         end
      end
      if (ctrl_rden)
      begin
         assert (exp_ctrl.size() != 0)
         else
         begin
            other_errs++;
            $display("ctrl fifo delivered a record word that no good frame should produce");
         end
         if (exp_ctrl.size() != 0)
         begin
            ec = exp_ctrl.pop_front();
            assert (ctrl_rdata == ec)
            else
            begin
               ctrl_errs++;
               $display("Error: ctrl_rdata got %h expected %h", ctrl_rdata, ec);
            end
         end
      end
   endtask

   // random pops, never back to back
   // so a non-empty flag seen before the edge still holds after it
   task automatic drive_reads();
      logic [63:0] r;
      take_bits(2, r);
      good_rden <= r[0] && !good_empty && !good_rden;
      ctrl_rden <= r[1] && !ctrl_empty && !ctrl_rden;
   endtask

   // one clock: check pops, then drive the next cycle's inputs
   task automatic step_cycle(input logic valid, input rx_beat_t beat, input logic err,
                             input logic mc);
      @(posedge s2mm_clk);
      check_pops();
      drive_reads();
      mac_valid <= valid;
      mac_beat  <= beat;
      mac_error <= err;
      mac_mcast <= mc;
   endtask

   // 2 to 8 beats, full keep except a thermometer keep on the last
   task automatic send_frame();
      logic [63:0] r;
      int          nbeats;
      int          kbytes;
      logic        err;
      logic        mc;
      rx_beat_t    b;
      take_bits(3, r);
      nbeats = 2 + int'(r[2:0]) % 7;
      take_bits(3, r);
      kbytes = 1 + int'(r[2:0]);
      take_bits(2, r);
      err = r[0];
      mc  = r[1];
      for (int i = 0; i < nbeats; i++)
      begin
         take_bits(64, r);
         b.data = r;
         b.last = (i == nbeats - 1);
         b.keep = b.last ? 8'((9'd1 << kbytes) - 9'd1) : 8'hff;
         // bad frames leave no trace downstream
         if (!err)
         begin
            exp_good.push_back(b);
         end
         step_cycle(1'b1, b, err && b.last, mc && b.last);
      end
      if (err)
      begin
         bad_frames++;
      end
      else
      begin
         good_frames++;
         push_record(mc, 16'(8 * (nbeats - 1) + kbytes));
      end
   endtask

   // spacing between frames, 16 to 23 idle cycles
   task automatic idle_gap();
      logic [63:0] r;
      take_bits(3, r);
      repeat (MIN_GAP + int'(r[2:0]))
      begin
         step_cycle(1'b0, '0, 1'b0, 1'b0);
      end
   endtask

   task automatic report_counts();
      $display("errors: good=%0d ctrl=%0d other=%0d, frames sent good=%0d bad=%0d",
               good_errs, ctrl_errs, other_errs, good_frames, bad_frames);
   endtask

   initial
   begin
      s2mm_clk    = 1'b0;
      s2mm_resetn = 1'b0;
      mac_valid   = 1'b0;
      mac_beat    = '0;
      mac_error   = 1'b0;
      mac_mcast   = 1'b0;
      good_rden   = 1'b0;
      ctrl_rden   = 1'b0;
      lfsr        = 16'd8115;
      good_errs   = 0;
      ctrl_errs   = 0;
      other_errs  = 0;
      good_frames = 0;
      bad_frames  = 0;
      // reset held 4 cycles
      repeat (4)
      begin
         @(posedge s2mm_clk);
      end
      s2mm_resetn <= 1'b1;
      for (int f = 0; f < NUM_FRAMES; f++)
      begin
         send_frame();
         idle_gap();
      end
      // drain until the model is satisfied
      while (exp_good.size() != 0 || exp_ctrl.size() != 0)
      begin
         step_cycle(1'b0, '0, 1'b0, 1'b0);
      end
      // extra cycles catch stray output words
      repeat (DRAIN_CYCLES)
      begin
         step_cycle(1'b0, '0, 1'b0, 1'b0);
      end
      assert (good_empty)
      else
      begin
         other_errs++;
         $display("good fifo still holds data after the drain");
      end
      assert (ctrl_empty)
      else
      begin
         other_errs++;
         $display("ctrl fifo still holds data after the drain");
      end
      assert (ovf_drops == 16'h0000)
      else
      begin
         other_errs++;
         $display("Error: ovf_drops got %h expected %h", ovf_drops, 16'h0000);
      end
      report_counts();
      if (good_errs + ctrl_errs + other_errs == 0)
      begin
         $display("TEST PASS");
      end
      else
      begin
         $display("TEST FAIL");
      end
      $finish;
   end

   // hang guard
   initial
   begin
      #(WATCHDOG_TIME);
      $display("watchdog expired after %0d time units, the run hung", WATCHDOG_TIME);
      report_counts();
      $display("TEST FAIL");
      $finish;
   end

endmodule
